// File: hw/issue_pkg.sv
// Shared widths, encodings and types for the RV32I issue slice.
// Every design file refers to these through issue_pkg:: scoped names.

package issue_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [31:0]     instr_t;
    typedef logic [31:0]     pc_t;
    typedef logic [4:0]      reg_addr_t;

    // Opcode without the two low bits, which are always 2'b11
    typedef logic [4:0]      opcode_t;

    //////////////////////////////////////////////////
    // Opcodes kept in this slice
    localparam opcode_t OP_ARITH_T     = 5'b01100;
    localparam opcode_t OP_ARITH_IMM_T = 5'b00100;
    localparam opcode_t OP_LUI_T       = 5'b01101;
    localparam opcode_t OP_AUIPC_T     = 5'b00101;

    //////////////////////////////////////////////////
    // funct3 codes of the integer group
    localparam logic [2:0] FN3_ADD_SUB = 3'b000;
    localparam logic [2:0] FN3_SLL     = 3'b001;
    localparam logic [2:0] FN3_SLT     = 3'b010;
    localparam logic [2:0] FN3_SLTU    = 3'b011;
    localparam logic [2:0] FN3_XOR     = 3'b100;
    localparam logic [2:0] FN3_SRL_SRA = 3'b101;
    localparam logic [2:0] FN3_OR      = 3'b110;
    localparam logic [2:0] FN3_AND     = 3'b111;

    // ALU operation selected at decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_t;

endpackage

// File: hw/issue_ifs.sv
// Stage-to-stage buses of the issue slice.
// exec_if runs from decode to the ALU, wb_if from the ALU to writeback.

`timescale 1ns/1ps

// Issued operation with its operands and sideband
interface exec_if;
    logic                 valid;
    issue_pkg::alu_op_t   op;
    issue_pkg::data_t     a;
    issue_pkg::data_t     b;
    issue_pkg::pc_t       pc;
    issue_pkg::reg_addr_t rd;
    logic                 writes_rd;
    logic                 illegal;

    modport issue (output valid, op, a, b, pc, rd, writes_rd, illegal);
    modport execute (input valid, op, a, b, pc, rd, writes_rd, illegal);
    // Writeback watches issues to reserve credits and mark rd busy
    modport monitor (input valid, rd, writes_rd);
endinterface

// Registered ALU result heading for the register file and result port
interface wb_if;
    logic                 valid;
    issue_pkg::pc_t       pc;
    issue_pkg::reg_addr_t rd;
    logic                 writes_rd;
    logic                 illegal;
    issue_pkg::data_t     data;

    modport source (output valid, pc, rd, writes_rd, illegal, data);
    modport sink (input valid, pc, rd, writes_rd, illegal, data);
endinterface

// File: hw/instr_decode.sv
// Issue stage: small instruction queue, field decode, operand read and
// hazard check. One instr_credit pulse goes back upstream per issue.

`timescale 1ns/1ps

module instr_decode #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  issue_pkg::instr_t              instr,
    input  issue_pkg::pc_t                 instr_pc,
    output logic                           instr_credit,
    output issue_pkg::reg_addr_t           rs1_addr,
    output issue_pkg::reg_addr_t           rs2_addr,
    input  issue_pkg::data_t               rs1_data,
    input  issue_pkg::data_t               rs2_data,
    input  logic [issue_pkg::NUM_REGS-1:0] busy,
    input  logic                           slot_free,
    exec_if.issue                          ex
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    issue_pkg::instr_t  q_instr [QUEUE_DEPTH];
    issue_pkg::pc_t     q_pc    [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    issue_pkg::instr_t  head;
    issue_pkg::pc_t     head_pc;
    logic               head_valid;
    issue_pkg::opcode_t opcode;
    logic [2:0]         fn3;
    logic [6:0]         fn7;
    logic               is_arith;
    logic               is_imm;
    logic               is_lui;
    logic               is_auipc;
    logic               fn7_ok;
    logic               legal;
    logic               uses_rs1;
    logic               uses_rs2;
    logic               issue;
    issue_pkg::alu_op_t op;
    issue_pkg::data_t   imm_i;
    issue_pkg::data_t   imm_u;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1))
            return '0;
        else
            return p + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Instruction queue
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (instr_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (issue)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(instr_valid) - CNT_W'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_instr[wr_ptr] <= instr;
            q_pc[wr_ptr]    <= instr_pc;
        end
    end

    assign head       = q_instr[rd_ptr];
    assign head_pc    = q_pc[rd_ptr];
    assign head_valid = (count != '0);

    //////////////////////////////////////////////////
    // Field decode of the queue head
    assign opcode   = head[6:2];
    assign fn3      = head[14:12];
    assign fn7      = head[31:25];
    assign rs1_addr = head[19:15];
    assign rs2_addr = head[24:20];

    assign is_arith = (opcode == issue_pkg::OP_ARITH_T);
    assign is_imm   = (opcode == issue_pkg::OP_ARITH_IMM_T);
    assign is_lui   = (opcode == issue_pkg::OP_LUI_T);
    assign is_auipc = (opcode == issue_pkg::OP_AUIPC_T);

    // Only bit 30 may be set in funct7, and only for SUB and SRA/SRAI
    always_comb begin
        if (is_arith)
            fn7_ok = (fn7 == 7'b0) || (fn7 == 7'b0100000 &&
                     (fn3 == issue_pkg::FN3_ADD_SUB || fn3 == issue_pkg::FN3_SRL_SRA));
        else if (is_imm && (fn3 == issue_pkg::FN3_SLL || fn3 == issue_pkg::FN3_SRL_SRA))
            fn7_ok = (fn7 == 7'b0) || (fn7 == 7'b0100000 && fn3 == issue_pkg::FN3_SRL_SRA);
        else
            fn7_ok = 1'b1;
    end

    assign legal = (head[1:0] == 2'b11) && (is_arith || is_imm || is_lui || is_auipc) && fn7_ok;

    always_comb begin
        case (fn3)
            issue_pkg::FN3_ADD_SUB: op = (is_arith && head[30]) ? issue_pkg::ALU_SUB
                                                                : issue_pkg::ALU_ADD;
            issue_pkg::FN3_SLL:     op = issue_pkg::ALU_SLL;
            issue_pkg::FN3_SLT:     op = issue_pkg::ALU_SLT;
            issue_pkg::FN3_SLTU:    op = issue_pkg::ALU_SLTU;
            issue_pkg::FN3_XOR:     op = issue_pkg::ALU_XOR;
            issue_pkg::FN3_SRL_SRA: op = head[30] ? issue_pkg::ALU_SRA : issue_pkg::ALU_SRL;
            issue_pkg::FN3_OR:      op = issue_pkg::ALU_OR;
            issue_pkg::FN3_AND:     op = issue_pkg::ALU_AND;
            default:                op = issue_pkg::ALU_ADD;
        endcase
        // Upper-immediate forms ignore funct3
        if (is_lui)
            op = issue_pkg::ALU_PASS_B;
        else if (is_auipc)
            op = issue_pkg::ALU_ADD;
    end

    assign imm_i = {{20{head[31]}}, head[31:20]};
    assign imm_u = {head[31:12], 12'b0};

    //////////////////////////////////////////////////
    // Hazard check and issue
    assign uses_rs1 = legal && (is_arith || is_imm);
    assign uses_rs2 = legal && is_arith;

    assign issue = head_valid && slot_free &&
                   !(uses_rs1 && busy[rs1_addr]) && !(uses_rs2 && busy[rs2_addr]);
    assign instr_credit = issue;

    always_ff @(posedge clk) begin
        if (rst)
            ex.valid <= 1'b0;
        else
            ex.valid <= issue;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ex.op        <= op;
            ex.a         <= is_auipc ? head_pc : (uses_rs1 ? rs1_data : '0);
            ex.b         <= uses_rs2 ? rs2_data : ((is_lui || is_auipc) ? imm_u : imm_i);
            ex.pc        <= head_pc;
            ex.rd        <= head[11:7];
            ex.writes_rd <= legal && (head[11:7] != '0);
            ex.illegal   <= !legal;
        end
    end

    // Full queue takes a push only while its head leaves that cycle
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> (count < CNT_W'(QUEUE_DEPTH)) || issue);

    // Sources never match the destination still sitting in the ALU stage
    a_no_raw: assert property (@(posedge clk) disable iff (rst)
        issue && ex.valid && ex.writes_rd |->
            !(uses_rs1 && rs1_addr == ex.rd) && !(uses_rs2 && rs2_addr == ex.rd));

endmodule

// File: hw/alu_execute.sv
// Integer ALU stage. Takes one issued operation per cycle from exec_if
// and registers the result with its sideband onto wb_if.

`timescale 1ns/1ps

module alu_execute (
    input logic     clk,
    input logic     rst,
    exec_if.execute ex,
    wb_if.source    wb
);
    issue_pkg::data_t result;
    logic [4:0]       shamt;

    // Shifts use only the low five bits of the second operand
    assign shamt = ex.b[4:0];

    always_comb begin
        case (ex.op)
            issue_pkg::ALU_ADD:    result = ex.a + ex.b;
            issue_pkg::ALU_SUB:    result = ex.a - ex.b;
            issue_pkg::ALU_SLT:    result = issue_pkg::data_t'($signed(ex.a) < $signed(ex.b));
            issue_pkg::ALU_SLTU:   result = issue_pkg::data_t'(ex.a < ex.b);
            issue_pkg::ALU_XOR:    result = ex.a ^ ex.b;
            issue_pkg::ALU_OR:     result = ex.a | ex.b;
            issue_pkg::ALU_AND:    result = ex.a & ex.b;
            issue_pkg::ALU_SLL:    result = ex.a << shamt;
            issue_pkg::ALU_SRL:    result = ex.a >> shamt;
            issue_pkg::ALU_SRA:    result = issue_pkg::data_t'($signed(ex.a) >>> shamt);
            issue_pkg::ALU_PASS_B: result = ex.b;
            default:               result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register
    always_ff @(posedge clk) begin
        if (rst)
            wb.valid <= 1'b0;
        else
            wb.valid <= ex.valid;
    end

    always_ff @(posedge clk) begin
        if (ex.valid) begin
            wb.data      <= result;
            wb.pc        <= ex.pc;
            wb.rd        <= ex.rd;
            wb.writes_rd <= ex.writes_rd;
            wb.illegal   <= ex.illegal;
        end
    end

    // Decode must never let an illegal instruction claim a register
    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        ex.valid && ex.illegal |-> !ex.writes_rd);

endmodule

// File: hw/result_writeback.sv
// Writeback stage: register file, busy scoreboard and output credits.
// Results leave on the result_* ports in the cycle they are written.

`timescale 1ns/1ps

module result_writeback #(
    parameter int RESULT_CREDITS = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    exec_if.monitor                        ex_mon,
    wb_if.sink                             wb,
    input  issue_pkg::reg_addr_t           rs1_addr,
    input  issue_pkg::reg_addr_t           rs2_addr,
    output issue_pkg::data_t               rs1_data,
    output issue_pkg::data_t               rs2_data,
    output logic [issue_pkg::NUM_REGS-1:0] busy,
    output logic                           slot_free,
    output logic                           result_valid,
    output issue_pkg::pc_t                 result_pc,
    output issue_pkg::reg_addr_t           result_rd,
    output issue_pkg::data_t               result_data,
    output logic                           result_illegal,
    input  logic                           result_credit
);
    localparam int NREGS  = issue_pkg::NUM_REGS;
    localparam int CRED_W = $clog2(RESULT_CREDITS + 1);

    issue_pkg::data_t  regs [NREGS];
    logic [NREGS-1:0]  written;
    logic [NREGS-1:0]  busy_r;
    logic [NREGS-1:0]  set_mask;
    logic [NREGS-1:0]  clr_mask;
    logic [CRED_W-1:0] credits;
    logic              wr_en;

    //////////////////////////////////////////////////
    // Register file, x0 never written
    assign wr_en = wb.valid && wb.writes_rd && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en)
            regs[wb.rd] <= wb.data;
    end

    // Registers not yet written since reset read as zero
    always_ff @(posedge clk) begin
        if (rst)
            written <= '0;
        else if (wr_en)
            written[wb.rd] <= 1'b1;
    end

    assign rs1_data = written[rs1_addr] ? regs[rs1_addr] : '0;
    assign rs2_data = written[rs2_addr] ? regs[rs2_addr] : '0;

    //////////////////////////////////////////////////
    // Scoreboard, set at issue and cleared at write
    assign set_mask = (ex_mon.valid && ex_mon.writes_rd) ? (NREGS'(1) << ex_mon.rd) : '0;
    assign clr_mask = (wb.valid && wb.writes_rd) ? (NREGS'(1) << wb.rd) : '0;

    // A new writer to the same rd wins over the older one finishing
    always_ff @(posedge clk) begin
        if (rst)
            busy_r <= '0;
        else
            busy_r <= (busy_r & ~clr_mask) | set_mask;
    end

    // Item in the ALU stage counts as busy before it reaches busy_r
    assign busy = busy_r | set_mask;

    //////////////////////////////////////////////////
    // Output credits, reserved when the item reaches the ALU stage
    always_ff @(posedge clk) begin
        if (rst)
            credits <= CRED_W'(RESULT_CREDITS);
        else
            credits <= credits + CRED_W'(result_credit) - CRED_W'(ex_mon.valid);
    end

    assign slot_free = (credits > CRED_W'(ex_mon.valid));

    assign result_valid   = wb.valid;
    assign result_pc      = wb.pc;
    assign result_rd      = wb.rd;
    assign result_data    = wb.data;
    assign result_illegal = wb.illegal;

    // Downstream never returns more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_W'(RESULT_CREDITS));

endmodule

// File: hw/issue_top.sv
// Top level of the RV32I issue slice: decode, ALU and writeback stages
// joined by the stage buses. Credit flow control on both sides.

`timescale 1ns/1ps

module issue_top #(
    parameter int QUEUE_DEPTH    = 2,
    parameter int RESULT_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  issue_pkg::instr_t    instr,
    input  issue_pkg::pc_t       instr_pc,
    output logic                 instr_credit,
    output logic                 result_valid,
    output issue_pkg::pc_t       result_pc,
    output issue_pkg::reg_addr_t result_rd,
    output issue_pkg::data_t     result_data,
    output logic                 result_illegal,
    input  logic                 result_credit
);
    issue_pkg::reg_addr_t           rs1_addr;
    issue_pkg::reg_addr_t           rs2_addr;
    issue_pkg::data_t               rs1_data;
    issue_pkg::data_t               rs2_data;
    logic [issue_pkg::NUM_REGS-1:0] busy;
    logic                           slot_free;

    exec_if ex_bus ();
    wb_if   wb_bus ();

    instr_decode #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_decode (
        .clk, .rst, .instr_valid, .instr, .instr_pc, .instr_credit,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .busy, .slot_free,
        .ex(ex_bus)
    );

    alu_execute u_alu (.clk, .rst, .ex(ex_bus), .wb(wb_bus));

    result_writeback #(.RESULT_CREDITS(RESULT_CREDITS)) u_wb (
        .clk, .rst, .ex_mon(ex_bus), .wb(wb_bus),
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .busy, .slot_free,
        .result_valid, .result_pc, .result_rd, .result_data, .result_illegal,
        .result_credit
    );

endmodule

// File: verification/issue_tb.sv
// Testbench for the issue slice. Sends an LFSR-driven instruction stream under
// input credits, checks each result against an ISA model kept in program
// order, and withholds output credits in random stretches.

`timescale 1ns/1ps

module issue_tb;
    localparam int QUEUE_DEPTH    = 2;
    localparam int RESULT_CREDITS = 4;
    localparam int PER_TEST       = 100;
    localparam int N_INSTR        = 4 * PER_TEST;
    localparam int IDX_W          = $clog2(N_INSTR);

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        instr_credit;
    logic        result_valid;
    logic [31:0] result_pc;
    logic [4:0]  result_rd;
    logic [31:0] result_data;
    logic        result_illegal;
    logic        result_credit;

    // Expected results indexed by program order
    logic [31:0] exp_data    [N_INSTR];
    logic [31:0] exp_pc      [N_INSTR];
    logic [4:0]  exp_rd      [N_INSTR];
    logic        exp_illegal [N_INSTR];
    int          exp_test    [N_INSTR];
    logic [31:0] model_regs  [32];

    logic [31:0] stim_lfsr;
    logic [31:0] gap_lfsr;
    logic [31:0] next_pc;
    logic [4:0]  last_rd;
    int          n_built;
    int          hold_cnt;
    int          sent_cnt;
    int          crd_back;
    int          res_cnt;
    int          crd_given;

    logic [31:0] cur_data;
    logic [31:0] cur_pc;
    logic [4:0]  cur_rd;
    logic        cur_illegal;
    int          cur_test;

    issue_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .RESULT_CREDITS(RESULT_CREDITS)) u_dut (
        .clk, .rst, .instr_valid, .instr, .instr_pc, .instr_credit,
        .result_valid, .result_pc, .result_rd, .result_data, .result_illegal,
        .result_credit
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers

    // Taps x^32 + x^22 + x^2 + x + 1 with one step per bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] st, input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb  = st[31] ^ st[21] ^ st[1] ^ st[0];
            st  = {st[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // Ops numbered add sub sll slt sltu xor srl sra or and
    function automatic logic [2:0] funct3_of(input int op);
        case (op)
            0, 1:    return 3'd0;
            2:       return 3'd1;
            3:       return 3'd2;
            4:       return 3'd3;
            5:       return 3'd4;
            6, 7:    return 3'd5;
            8:       return 3'd6;
            default: return 3'd7;
        endcase
    endfunction

    // Immediate forms in order addi slti sltiu xori ori andi slli srli srai
    function automatic int imm_op(input int k);
        case (k)
            0:       return 0;
            1:       return 3;
            2:       return 4;
            3:       return 5;
            4:       return 8;
            5:       return 9;
            6:       return 2;
            7:       return 6;
            default: return 7;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a << b[4:0];
            3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4:       return (a < b) ? 32'd1 : 32'd0;
            5:       return a ^ b;
            6:       return a >> b[4:0];
            7:       return 32'($signed(a) >>> b[4:0]);
            8:       return a | b;
            default: return a & b;
        endcase
    endfunction

    // Load, store, branch and system opcodes are outside this slice
    function automatic logic [6:0] illegal_opcode(input int k);
        case (k)
            0:       return 7'b0000011;
            1:       return 7'b0100011;
            2:       return 7'b1100011;
            default: return 7'b1110011;
        endcase
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0:       return "imm_upper";
            1:       return "reg_reg";
            2:       return "dependency";
            default: return "x0_illegal";
        endcase
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    // Instruction forms 0 R-type, 1 I-type, 2 LUI, 3 AUIPC and 4 illegal
    task automatic send_instr(input int test);
        int          op;
        int          form;
        int          k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [6:0]  f7;
        logic [31:0] w;
        logic [31:0] v;
        rd    = 5'(lfsr_take(stim_lfsr, 5));
        rs1   = 5'(lfsr_take(stim_lfsr, 5));
        rs2   = 5'(lfsr_take(stim_lfsr, 5));
        imm12 = 12'(lfsr_take(stim_lfsr, 12));
        imm20 = 20'(lfsr_take(stim_lfsr, 20));
        op    = int'(lfsr_take(stim_lfsr, 4) % 10);
        k     = int'(lfsr_take(stim_lfsr, 4));
        form  = 0;
        case (test)
            0: begin
                form = (k % 11 < 9) ? 1 : (k % 11 == 9) ? 2 : 3;
                op   = imm_op(k % 11);
            end
            1: form = 0;
            2: begin
                form = k % 2;
                rs1  = last_rd;
                if (k[1])
                    rs2 = last_rd;
                if (form == 1)
                    op = imm_op(op % 9);
                if (rd == 5'd0)
                    rd = 5'd1;
            end
            default: begin
                if (k % 4 == 0)
                    rd = 5'd0;
                else if (k % 4 == 1)
                    rs1 = 5'd0;
                else
                    form = 4;
            end
        endcase

        if (form == 1 && (op == 2 || op == 6 || op == 7))
            imm12[11:5] = (op == 7) ? 7'b0100000 : 7'b0;
        case (form)
            0: begin
                f7 = (op == 1 || op == 7) ? 7'b0100000 : 7'b0;
                w  = {f7, rs2, rs1, funct3_of(op), rd, 7'b0110011};
                v  = alu_ref(op, model_regs[rs1], model_regs[rs2]);
            end
            1: begin
                w = {imm12, rs1, funct3_of(op), rd, 7'b0010011};
                v = alu_ref(op, model_regs[rs1], {{20{imm12[11]}}, imm12});
            end
            2: begin
                w = {imm20, rd, 7'b0110111};
                v = {imm20, 12'b0};
            end
            3: begin
                w = {imm20, rd, 7'b0010111};
                v = next_pc + {imm20, 12'b0};
            end
            default: begin
                w = {imm20, rd, illegal_opcode(k % 4)};
                v = '0;
            end
        endcase
        if (form != 4 && rd != 5'd0)
            model_regs[rd] = v;
        last_rd = rd;

        exp_data[n_built[IDX_W-1:0]]    = v;
        exp_pc[n_built[IDX_W-1:0]]      = next_pc;
        exp_rd[n_built[IDX_W-1:0]]      = rd;
        exp_illegal[n_built[IDX_W-1:0]] = (form == 4);
        exp_test[n_built[IDX_W-1:0]]    = test;
        n_built = n_built + 1;

        // Send only while an input credit is held
        while (sent_cnt >= QUEUE_DEPTH + crd_back)
            @(negedge clk);
        instr_valid = 1'b1;
        instr       = w;
        instr_pc    = next_pc;
        next_pc     = next_pc + 32'd4;
        @(negedge clk);
        instr_valid = 1'b0;
        if (lfsr_take(stim_lfsr, 2) == 0)
            @(negedge clk);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        stim_lfsr   = 32'd99177;
        next_pc     = 32'h0000_1000;
        last_rd     = 5'd1;
        n_built     = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < 4; t++) begin
            for (int n = 0; n < PER_TEST; n++)
                send_instr(t);
        end
        while (res_cnt < N_INSTR)
            @(negedge clk);
        repeat (4) @(negedge clk);
        if (crd_back == sent_cnt && sent_cnt == N_INSTR) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_error($sformatf("input credits returned %0d but %0d instructions sent",
                                      crd_back, sent_cnt));
        end
    end

    // Downstream returns credits with long random stretches of holding back
    initial begin
        result_credit = 1'b0;
        hold_cnt      = 0;
        gap_lfsr      = 32'd99177;
        forever begin
            @(negedge clk);
            if (rst || hold_cnt > 0 || res_cnt <= crd_given) begin
                result_credit = 1'b0;
                if (hold_cnt > 0)
                    hold_cnt = hold_cnt - 1;
            end else begin
                result_credit = 1'b1;
                if (lfsr_take(gap_lfsr, 3) == 0)
                    hold_cnt = int'(lfsr_take(gap_lfsr, 6));
            end
        end
    end

    initial begin
        repeat (N_INSTR * 20 + 200) @(posedge clk);
        stop_with_error("watchdog expired before all results came back");
    end

    //////////////////////////////////////////////////
    // Bookkeeping and checks
    always @(posedge clk) begin
        if (rst) begin
            sent_cnt  <= 0;
            crd_back  <= 0;
            res_cnt   <= 0;
            crd_given <= 0;
        end else begin
            if (instr_valid)
                sent_cnt <= sent_cnt + 1;
            if (instr_credit)
                crd_back <= crd_back + 1;
            if (result_valid)
                res_cnt <= res_cnt + 1;
            if (result_credit)
                crd_given <= crd_given + 1;
        end
    end

    assign cur_data    = exp_data[res_cnt[IDX_W-1:0]];
    assign cur_pc      = exp_pc[res_cnt[IDX_W-1:0]];
    assign cur_rd      = exp_rd[res_cnt[IDX_W-1:0]];
    assign cur_illegal = exp_illegal[res_cnt[IDX_W-1:0]];
    assign cur_test    = exp_test[res_cnt[IDX_W-1:0]];

    a_result_expected: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> res_cnt < sent_cnt)
        else stop_with_error("result appeared with no instruction outstanding");

    a_result_pc: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> result_pc == cur_pc)
        else stop_with_error($sformatf("mismatch %s result_pc expected %h actual %h",
            test_name($sampled(cur_test)), $sampled(cur_pc), $sampled(result_pc)));

    a_result_rd: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> result_rd == cur_rd)
        else stop_with_error($sformatf("mismatch %s result_rd expected %h actual %h",
            test_name($sampled(cur_test)), $sampled(cur_rd), $sampled(result_rd)));

    a_result_illegal: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> result_illegal == cur_illegal)
        else stop_with_error($sformatf("mismatch %s result_illegal expected %b actual %b",
            test_name($sampled(cur_test)), $sampled(cur_illegal), $sampled(result_illegal)));

    a_result_data: assert property (@(posedge clk) disable iff (rst)
        result_valid && !cur_illegal |-> result_data == cur_data)
        else stop_with_error($sformatf("mismatch %s result_data expected %h actual %h",
            test_name($sampled(cur_test)), $sampled(cur_data), $sampled(result_data)));

    a_out_credit: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> res_cnt < RESULT_CREDITS + crd_given)
        else stop_with_error("result sent without an output credit");

    a_in_credit_return: assert property (@(posedge clk) disable iff (rst)
        instr_credit |-> crd_back < sent_cnt)
        else stop_with_error("more input credits returned than instructions sent");

endmodule

// File: files.f
hw/issue_pkg.sv
hw/issue_ifs.sv
hw/instr_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/issue_top.sv
verification/issue_tb.sv

// File: Makefile
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

obj_dir/Vissue_tb: files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module issue_tb -f files.f

run: obj_dir/Vissue_tb
	@out="$$(./obj_dir/Vissue_tb 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
